//--- rv_core.f
rv_pkg.sv
ctrl_if.sv
decode.sv
regfile.sv
alu.sv
main_controller.sv
perf_counters.sv
core.sv
core_asserts.sv
tb_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_core -f rv_core.f -o sim_core
./obj_dir/sim_core > sim.log 2>&1
cat sim.log

if grep -q "Regression failed" sim.log; then
  exit 1
fi
exit 0

//--- tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core;
  import rv_pkg::*;

  localparam logic [31:0] END_PC = 32'd188;   // final self-loop, never served
  // fetch path from the first branch on, skipped stores left out
  localparam logic [31:0] TAIL_PC [10] = '{32'h7c, 32'h84, 32'h8c, 32'h90, 32'h94,
                                           32'h9c, 32'ha4, 32'ha8, 32'hb4, 32'hb8};

  logic        CLK, arst_n, fetch_valid, mem_read_data_valid, mem_write_ready, stall_debug;
  logic [31:0] instr_fetch, mem_read_data;
  logic [7:0]  DIP_switch;
  wire         fetch_enable, memory_en_out;
  wire  [31:0] PCfetch, mem_addr, mem_write_data, debug;
  wire  [1:0]  store_size;

  logic [31:0] rom [0:63];
  logic [7:0]  dm [0:255];                    // data region 0x100..0x1ff
  logic [31:0] exp_addr[$], exp_data[$], exp_pc[$];
  logic [1:0]  exp_size[$];
  integer      seed = 32'h907201b6;
  int          nwords, nstores, nfetch, fcnt, mcnt, waited;
  logic        fe_s, me_s, f_acc, m_acc;
  logic [31:0] pc_s, ad_s, wd_s;
  logic [1:0]  ss_s;
  logic [7:0]  a;

  core #(.RESET_PC(32'h0), .CNT_WIDTH(32)) dut (.*);

  initial CLK = 1'b0;
  always #10 CLK = ~CLK;

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  task automatic emit(input logic [31:0] w);
    rom[nwords] = w;
    nwords++;
  endtask

  task automatic expect_store(input logic [31:0] ad, input logic [1:0] sz, input logic [31:0] d);
    exp_addr.push_back(ad);
    exp_size.push_back(sz);
    exp_data.push_back(d);
  endtask

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_store();
    if (nstores >= exp_addr.size())
      report_error("unexpected extra store, a skipped store was executed");
    if (ad_s != exp_addr[nstores])
      report_error($sformatf("[FAIL] mem_addr got 0x%h expected 0x%h", ad_s, exp_addr[nstores]));
    if (ss_s != exp_size[nstores])
      report_error($sformatf("[FAIL] store_size got 0x%h expected 0x%h", ss_s,
                             exp_size[nstores]));
    if (wd_s != exp_data[nstores])
      report_error($sformatf("[FAIL] mem_write_data got 0x%h expected 0x%h", wd_s,
                             exp_data[nstores]));
    nstores++;
  endtask

  // accepted fetch addresses follow the program's known path
  task automatic check_fetch();
    if (nfetch >= exp_pc.size())
      report_error("fetch accepted beyond the end of the known path");
    if (pc_s != exp_pc[nfetch])
      report_error($sformatf("[FAIL] PCfetch got 0x%h expected 0x%h", pc_s, exp_pc[nfetch]));
    nfetch++;
  endtask

  // answers a pending load or store, data sits in the low bits
  task automatic serve_mem();
    if (ad_s[31:8] != 24'h000001)
      report_error("memory access outside the data region");
    a = ad_s[7:0];
    if (ss_s == STORE_READ) begin
      mem_read_data = {dm[a + 8'd3], dm[a + 8'd2], dm[a + 8'd1], dm[a]};
      mem_read_data_valid = 1'b1;
    end else begin
      check_store();
      dm[a] = wd_s[7:0];
      if (ss_s != 2'b00) dm[a + 8'd1] = wd_s[15:8];
      if (ss_s == 2'b10) begin
        dm[a + 8'd2] = wd_s[23:16];
        dm[a + 8'd3] = wd_s[31:24];
      end
      mem_write_ready = 1'b1;
    end
  endtask

  // fetch and memory responder, samples at the edge and drives 1 ns later
  always @(posedge CLK) begin
    fe_s  = fetch_enable;
    pc_s  = PCfetch;
    me_s  = memory_en_out;
    ss_s  = store_size;
    ad_s  = mem_addr;
    wd_s  = mem_write_data;
    f_acc = fetch_enable && fetch_valid;
    m_acc = memory_en_out && (mem_read_data_valid || mem_write_ready);
    if (f_acc) check_fetch();
    #1;
    fetch_valid         = 1'b0;
    mem_read_data_valid = 1'b0;
    mem_write_ready     = 1'b0;
    if (fe_s && !f_acc && pc_s != END_PC) begin
      if (fcnt < 0) fcnt = $unsigned($random(seed)) % 4;
      if (fcnt == 0) begin
        fetch_valid = 1'b1;
        instr_fetch = rom[pc_s[7:2]];
      end
      fcnt = fcnt - 1;
    end
    if (me_s && !m_acc) begin
      if (mcnt < 0) mcnt = $unsigned($random(seed)) % 4;
      if (mcnt == 0) serve_mem();
      mcnt = mcnt - 1;
    end
  end

  initial begin
    arst_n = 1'b0;
    fetch_valid = 1'b0;
    instr_fetch = 32'h0;
    mem_read_data = 32'h0;
    mem_read_data_valid = 1'b0;
    mem_write_ready = 1'b0;
    DIP_switch = 8'h40;
    stall_debug = 1'b0;
    nwords = 0;
    nstores = 0;
    nfetch = 0;
    fcnt = -1;
    mcnt = -1;
    for (int i = 0; i < 64; i++) rom[i] = 32'h0000_0013;
    for (int i = 0; i < 256; i++) dm[i] = 8'(i) ^ 8'ha5;

    emit(i_type(12'd256, 5'd0, 3'b000, 5'd10, OPC_OP_IMM));   // x10 = data base
    emit(i_type(12'd5, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
    emit(i_type(12'hffd, 5'd0, 3'b000, 5'd2, OPC_OP_IMM));    // x2 = -3
    emit(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd3));             // sub
    emit(s_type(12'd0, 5'd3, 5'd10, 3'b010));
    emit(r_type(7'h20, 5'd1, 5'd2, 3'b101, 5'd4));             // sra
    emit(r_type(7'h00, 5'd1, 5'd4, 3'b100, 5'd4));             // xor
    emit(s_type(12'd4, 5'd4, 5'd10, 3'b010));
    emit(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd5));             // slt
    emit(r_type(7'h00, 5'd2, 5'd1, 3'b011, 5'd6));             // sltu, 5 below 0xfffffffd
    emit(i_type(12'd4, 5'd5, 3'b001, 5'd7, OPC_OP_IMM));       // slli
    emit(r_type(7'h00, 5'd6, 5'd7, 3'b110, 5'd7));             // or
    emit(s_type(12'd8, 5'd7, 5'd10, 3'b010));
    emit(u_type(20'h12345, 5'd8, OPC_LUI));
    emit(i_type(12'd4, 5'd8, 3'b101, 5'd8, OPC_OP_IMM));       // srli
    emit(u_type(20'h00001, 5'd9, OPC_AUIPC));                  // at pc 0x3c
    emit(r_type(7'h00, 5'd8, 5'd9, 3'b000, 5'd9));
    emit(s_type(12'd12, 5'd9, 5'd10, 3'b010));
    emit(s_type(12'd16, 5'd2, 5'd10, 3'b000));                 // sb
    emit(s_type(12'd20, 5'd2, 5'd10, 3'b001));                 // sh
    emit(i_type(12'd16, 5'd10, 3'b000, 5'd11, OPC_LOAD));      // lb
    emit(i_type(12'd16, 5'd10, 3'b100, 5'd12, OPC_LOAD));      // lbu
    emit(s_type(12'd24, 5'd11, 5'd10, 3'b010));
    emit(s_type(12'd28, 5'd12, 5'd10, 3'b010));
    emit(i_type(12'd20, 5'd10, 3'b001, 5'd13, OPC_LOAD));      // lh
    emit(i_type(12'd20, 5'd10, 3'b101, 5'd14, OPC_LOAD));      // lhu
    emit(r_type(7'h00, 5'd14, 5'd13, 3'b100, 5'd13));
    emit(s_type(12'd32, 5'd13, 5'd10, 3'b010));
    emit(i_type(12'd12, 5'd10, 3'b010, 5'd15, OPC_LOAD));      // lw
    emit(s_type(12'd36, 5'd15, 5'd10, 3'b010));
    emit(b_type(13'd8, 5'd2, 5'd1, 3'b000));                   // beq, not taken
    emit(b_type(13'd8, 5'd2, 5'd1, 3'b001));                   // bne, taken
    emit(s_type(12'd0, 5'd0, 5'd10, 3'b010));
    emit(b_type(13'd8, 5'd1, 5'd2, 3'b100));                   // blt, taken
    emit(s_type(12'd0, 5'd0, 5'd10, 3'b010));
    emit(b_type(13'd8, 5'd1, 5'd2, 3'b101));                   // bge, not taken
    emit(b_type(13'd8, 5'd1, 5'd2, 3'b110));                   // bltu, not taken
    emit(b_type(13'd8, 5'd1, 5'd2, 3'b111));                   // bgeu, taken
    emit(s_type(12'd0, 5'd0, 5'd10, 3'b010));
    emit(j_type(21'd8, 5'd16));                                // jal, link 0xa0
    emit(s_type(12'd0, 5'd0, 5'd10, 3'b010));
    emit(i_type(12'd180, 5'd0, 3'b000, 5'd17, OPC_OP_IMM));
    emit(i_type(12'd0, 5'd17, 3'b000, 5'd18, OPC_JALR));       // link 0xac
    emit(s_type(12'd0, 5'd0, 5'd10, 3'b010));
    emit(s_type(12'd0, 5'd0, 5'd10, 3'b010));
    emit(s_type(12'd40, 5'd16, 5'd10, 3'b010));
    emit(s_type(12'd44, 5'd18, 5'd10, 3'b010));
    emit(j_type(21'd0, 5'd0));                                 // self loop

    for (int p = 0; p <= 32'h78; p += 4) exp_pc.push_back(32'(p));  // straight line code
    foreach (TAIL_PC[i]) exp_pc.push_back(TAIL_PC[i]);

    expect_store(32'h100, 2'b10, 32'h0000_0008);
    expect_store(32'h104, 2'b10, 32'hffff_fffa);
    expect_store(32'h108, 2'b10, 32'h0000_0011);
    expect_store(32'h10c, 2'b10, 32'h0123_553c);
    expect_store(32'h110, 2'b00, 32'h0000_00fd);
    expect_store(32'h114, 2'b01, 32'h0000_fffd);
    expect_store(32'h118, 2'b10, 32'hffff_fffd);
    expect_store(32'h11c, 2'b10, 32'h0000_00fd);
    expect_store(32'h120, 2'b10, 32'hffff_0000);
    expect_store(32'h124, 2'b10, 32'h0123_553c);
    expect_store(32'h128, 2'b10, 32'h0000_00a0);
    expect_store(32'h12c, 2'b10, 32'h0000_00ac);

    repeat (2) @(posedge CLK);
    #1 arst_n = 1'b1;

    waited = 0;
    while (nstores < 3) begin
      @(posedge CLK);
      waited++;
      if (waited > 500) report_error("timeout waiting for the third store");
    end
    #1 stall_debug = 1'b1;                    // freeze mid-program
    repeat (6) @(posedge CLK);
    #1 stall_debug = 1'b0;

    waited = 0;
    while (!(fetch_enable && PCfetch == END_PC)) begin
      @(posedge CLK);
      waited++;
      if (waited > 3000) report_error("timeout waiting for the final self-loop fetch");
    end

    #1 DIP_switch = 8'h51;                    // instret
    @(posedge CLK);
    if (debug != 32'd41)
      report_error($sformatf("[FAIL] debug got 0x%h expected 0x%h", debug, 32'd41));
    #1 DIP_switch = 8'h40;                    // pc
    @(posedge CLK);
    if (debug != END_PC)
      report_error($sformatf("[FAIL] debug got 0x%h expected 0x%h", debug, END_PC));

    if (nstores != exp_addr.size()) begin
      $display("only %0d of %0d expected stores were seen", nstores, exp_addr.size());
      $display("Regression failed");
      $fatal(1);
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- core_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module core_asserts (
  input wire logic        CLK,
  input wire logic        arst_n,
  input wire logic        fetch_enable,
  input wire logic [31:0] PCfetch,
  input wire logic        memory_en_out,
  input wire logic [1:0]  store_size,
  input wire logic [31:0] mem_addr,
  input wire logic [31:0] mem_write_data,
  input wire logic [31:0] debug,
  input wire logic        mem_read_data_valid,
  input wire logic        mem_write_ready,
  input wire logic        stall_debug
);
  import rv_pkg::*;

  logic mem_resp;

  assign mem_resp = (store_size == STORE_READ) ? mem_read_data_valid : mem_write_ready;

  a_fetch_mem_excl: assert property (@(posedge CLK) disable iff (!arst_n)
    !(fetch_enable && memory_en_out))
    else $error("fetch_enable and memory_en_out high together");

  a_pc_aligned: assert property (@(posedge CLK) disable iff (!arst_n)
    fetch_enable |-> PCfetch[1:0] == 2'b00)
    else $error("PCfetch not word aligned during fetch");

  a_stall_blocks_fetch: assert property (@(posedge CLK) disable iff (!arst_n)
    stall_debug |-> !fetch_enable)
    else $error("fetch_enable high while stall_debug is set");

  // request must hold until its response
  a_mem_hold: assert property (@(posedge CLK) disable iff (!arst_n)
    (memory_en_out && !mem_resp) |=> memory_en_out)
    else $error("memory_en_out dropped before the response");

  a_known: assert property (@(posedge CLK) disable iff (!arst_n)
    !$isunknown({fetch_enable, memory_en_out, PCfetch, store_size, mem_addr,
                 mem_write_data, debug}))
    else $error("unknown value on a core output");

endmodule

bind core core_asserts u_core_asserts (
  .CLK(CLK), .arst_n(arst_n), .fetch_enable(fetch_enable), .PCfetch(PCfetch),
  .memory_en_out(memory_en_out), .store_size(store_size), .mem_addr(mem_addr),
  .mem_write_data(mem_write_data), .debug(debug),
  .mem_read_data_valid(mem_read_data_valid), .mem_write_ready(mem_write_ready),
  .stall_debug(stall_debug)
);

`default_nettype wire

//--- core.sv
`timescale 1ns/1ps
`default_nettype none

module core #(
  parameter logic [31:0] RESET_PC  = 32'h0000_0000,
  parameter int          CNT_WIDTH = 32
) (
  input  logic        CLK,
  input  logic        arst_n,
  input  logic [31:0] instr_fetch,
  input  logic        fetch_valid,
  output logic        fetch_enable,
  output logic [31:0] PCfetch,
  output logic [31:0] mem_addr,
  output logic [31:0] mem_write_data,
  output logic [1:0]  store_size,   // 00 byte, 01 half, 10 word, 11 read
  output logic        memory_en_out,
  input  logic [31:0] mem_read_data,
  input  logic        mem_read_data_valid,
  input  logic        mem_write_ready,
  input  logic [7:0]  DIP_switch,
  input  logic        stall_debug,
  output logic [31:0] debug
);
  import rv_pkg::*;

  logic [31:0] pc, pc_plus4, next_pc, instr, rd1, rd2, alu_a, alu_b, alu_res, load_data, wd;
  logic [CNT_WIDTH-1:0] cycles, instret;
  logic mem_active, reg_we, retire, branch_taken;

  ctrl_if ctrl ();

  decode u_decode (.instr, .ctrl(ctrl.dec));

  regfile u_regfile (.CLK, .we(reg_we), .wa(ctrl.rd), .wd, .ra1(ctrl.rs1), .ra2(ctrl.rs2),
                     .rd1, .rd2);

  alu u_alu (.a(alu_a), .b(alu_b), .op(ctrl.alu_op), .funct3(ctrl.funct3), .rs1_val(rd1),
             .rs2_val(rd2), .result(alu_res), .branch_taken);

  main_controller #(.RESET_PC(RESET_PC)) u_main_controller (
    .CLK, .arst_n, .ctrl(ctrl.usr), .fetch_valid, .instr_fetch, .stall_debug,
    .mem_read_data_valid, .mem_write_ready, .next_pc, .pc, .instr, .fetch_enable,
    .mem_active, .reg_we, .retire);

  perf_counters #(.CNT_WIDTH(CNT_WIDTH)) u_perf_counters (.CLK, .arst_n, .retire, .cycles,
                                                          .instret);

  assign alu_a    = ctrl.a_sel ? rd1 : pc;
  assign alu_b    = ctrl.b_sel ? rd2 : ctrl.imm;
  assign pc_plus4 = pc + 32'd4;
  // jump and taken branch targets come from the alu, bit 0 dropped for jalr
  assign next_pc  = (ctrl.jump || (ctrl.branch && branch_taken)) ? {alu_res[31:1], 1'b0}
                                                                 : pc_plus4;

  assign PCfetch       = pc;
  assign mem_addr      = alu_res;       // misaligned addresses go out as they are
  assign store_size    = ctrl.store_size;
  assign memory_en_out = mem_active;

  always_comb begin
    case (ctrl.funct3)
      3'b000:  load_data = {{24{mem_read_data[7]}}, mem_read_data[7:0]};    // lb
      3'b001:  load_data = {{16{mem_read_data[15]}}, mem_read_data[15:0]};  // lh
      3'b100:  load_data = {24'h0, mem_read_data[7:0]};                     // lbu
      3'b101:  load_data = {16'h0, mem_read_data[15:0]};                    // lhu
      default: load_data = mem_read_data;                                   // lw
    endcase
    case (ctrl.store_size)
      2'b00:   mem_write_data = {24'h0, rd2[7:0]};
      2'b01:   mem_write_data = {16'h0, rd2[15:0]};
      2'b10:   mem_write_data = rd2;
      default: mem_write_data = 32'h0;   // read, nothing to write
    endcase
    case (ctrl.wd_sel)
      WD_ALU:  wd = alu_res;
      WD_MEM:  wd = load_data;
      WD_PC4:  wd = pc_plus4;
      default: wd = ctrl.imm;
    endcase
  end

  always_comb begin
    case (DIP_switch[6:0])
      7'b1000000: debug = pc;
      7'b1000001: debug = next_pc;
      7'b1000010: debug = instr;
      7'b1000011: debug = {3'b000, mem_active, 3'b000, fetch_enable, 3'b000, retire,
                           3'b000, stall_debug, 3'b000, arst_n, 3'b000, mem_write_ready,
                           3'b000, reg_we, 4'b0000};
      7'b1000100: debug = alu_res;
      7'b1000101: debug = load_data;
      7'b1000110: debug = mem_write_data;
      7'b1000111: debug = alu_a;
      7'b1001000: debug = alu_b;
      7'b1001001: debug = rd1;
      7'b1001010: debug = rd2;
      7'b1001011: debug = {ctrl.rs1, ctrl.rs2, 22'h000000};
      7'b1001110: debug = {ctrl.alu_op, 1'b0, ctrl.funct3, 3'b000, branch_taken, 20'h00000};
      7'b1001111: debug = wd;
      7'b1010000: debug = 32'(cycles);    // counters
      7'b1010001: debug = 32'(instret);
      default:    debug = pc;
    endcase
  end

endmodule

`default_nettype wire

//--- perf_counters.sv
`timescale 1ns/1ps
`default_nettype none

module perf_counters #(
  parameter int CNT_WIDTH = 32
) (
  input  logic                 CLK,
  input  logic                 arst_n,
  input  logic                 retire,
  output logic [CNT_WIDTH-1:0] cycles,
  output logic [CNT_WIDTH-1:0] instret
);

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      cycles  <= '0;
      instret <= '0;
    end else begin
      cycles <= cycles + CNT_WIDTH'(1);      // free running, wraps
      if (retire) begin
        instret <= instret + CNT_WIDTH'(1);
      end
    end
  end

endmodule

`default_nettype wire

//--- main_controller.sv
`timescale 1ns/1ps
`default_nettype none

module main_controller #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic        CLK,
  input  logic        arst_n,
  ctrl_if.usr         ctrl,
  input  logic        fetch_valid,
  input  logic [31:0] instr_fetch,
  input  logic        stall_debug,
  input  logic        mem_read_data_valid,
  input  logic        mem_write_ready,
  input  logic [31:0] next_pc,
  output logic [31:0] pc,
  output logic [31:0] instr,
  output logic        fetch_enable,
  output logic        mem_active,
  output logic        reg_we,
  output logic        retire
);
  import rv_pkg::*;

  localparam logic [31:0] NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

  state_e state_q, state_d;
  logic   run_q;     // first fetch one clock after reset release
  logic   mem_done;

  assign fetch_enable = run_q && state_q == ST_FETCH && !stall_debug;
  assign mem_active   = state_q == ST_MEM;
  assign mem_done     = ctrl.is_load ? mem_read_data_valid : mem_write_ready;

  // an instruction retires in exec, or in mem once its response arrives
  assign retire = (state_q == ST_EXEC && !ctrl.mem_en) || (mem_active && mem_done);
  assign reg_we = retire && ctrl.reg_we;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_FETCH: if (fetch_enable && fetch_valid) state_d = ST_EXEC;
      ST_EXEC:  state_d = ctrl.mem_en ? ST_MEM : ST_FETCH;
      ST_MEM:   if (mem_done) state_d = ST_FETCH;  // back-pressure just holds here
      default:  state_d = ST_FETCH;
    endcase
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= ST_FETCH;
      run_q   <= 1'b0;
      pc      <= RESET_PC;
      instr   <= NOP_INSTR;
    end else begin
      state_q <= state_d;
      run_q   <= 1'b1;
      if (retire) begin
        pc <= next_pc;
      end
      if (fetch_enable && fetch_valid) begin
        instr <= instr_fetch;
      end
    end
  end

endmodule

`default_nettype wire

//--- alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  logic [31:0]     a,
  input  logic [31:0]     b,
  input  rv_pkg::alu_op_e op,
  input  logic [2:0]      funct3,
  input  logic [31:0]     rs1_val,
  input  logic [31:0]     rs2_val,
  output logic [31:0]     result,
  output logic            branch_taken
);
  import rv_pkg::*;

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_SLL:  result = a << shamt;
      ALU_SLT:  result = {31'h0, $signed(a) < $signed(b)};
      ALU_SLTU: result = {31'h0, a < b};
      ALU_XOR:  result = a ^ b;
      ALU_SRL:  result = a >> shamt;
      ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
      ALU_OR:   result = a | b;
      ALU_AND:  result = a & b;
      default:  result = 32'h0;
    endcase
  end

  // branch comparator works on the register values, the alu adds pc + offset
  always_comb begin
    case (funct3)
      3'b000:  branch_taken = rs1_val == rs2_val;                     // beq
      3'b001:  branch_taken = rs1_val != rs2_val;                     // bne
      3'b100:  branch_taken = $signed(rs1_val) < $signed(rs2_val);    // blt
      3'b101:  branch_taken = $signed(rs1_val) >= $signed(rs2_val);   // bge
      3'b110:  branch_taken = rs1_val < rs2_val;                      // bltu
      3'b111:  branch_taken = rs1_val >= rs2_val;                     // bgeu
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
  input  logic        CLK,
  input  logic        we,
  input  logic [4:0]  wa,
  input  logic [31:0] wd,
  input  logic [4:0]  ra1,
  input  logic [4:0]  ra2,
  output logic [31:0] rd1,
  output logic [31:0] rd2
);

  logic [31:0] regs [1:31]; // x0 has no storage

  always_ff @(posedge CLK) begin
    if (we && wa != 5'd0) begin
      regs[wa] <= wd;
    end
  end

  // asynchronous read
  assign rd1 = (ra1 == 5'd0) ? 32'h0 : regs[ra1];
  assign rd2 = (ra2 == 5'd0) ? 32'h0 : regs[ra2];

endmodule

`default_nettype wire

//--- decode.sv
`timescale 1ns/1ps
`default_nettype none

module decode (
  input  logic [31:0] instr,
  ctrl_if.dec         ctrl
);
  import rv_pkg::*;

  opcode_e     opc;
  logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  alu_op_e     arith_op;

  assign opc         = opcode_e'(instr[6:0]);
  assign ctrl.rd     = instr[11:7];
  assign ctrl.funct3 = instr[14:12];
  assign ctrl.rs1    = instr[19:15];
  assign ctrl.rs2    = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'h000};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // funct3 / funct7 to alu operation, sub only exists for register-register
  always_comb begin
    case (instr[14:12])
      3'b000:  arith_op = (opc == OPC_OP && instr[30]) ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = instr[30] ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  always_comb begin
    ctrl.alu_op     = ALU_ADD;
    ctrl.a_sel      = 1'b1;
    ctrl.b_sel      = 1'b0;
    ctrl.wd_sel     = WD_ALU;
    ctrl.reg_we     = 1'b0;
    ctrl.mem_en     = 1'b0;
    ctrl.store_size = STORE_READ;
    ctrl.jump       = 1'b0;
    ctrl.branch     = 1'b0;
    ctrl.is_load    = 1'b0;
    ctrl.imm        = imm_i;
    case (opc)
      OPC_LUI: begin
        ctrl.imm    = imm_u;
        ctrl.wd_sel = WD_IMM;
        ctrl.reg_we = 1'b1;
      end
      OPC_AUIPC: begin
        ctrl.imm    = imm_u;
        ctrl.a_sel  = 1'b0;                  // pc + imm
        ctrl.reg_we = 1'b1;
      end
      OPC_JAL: begin
        ctrl.imm    = imm_j;
        ctrl.a_sel  = 1'b0;
        ctrl.jump   = 1'b1;
        ctrl.wd_sel = WD_PC4;                // link
        ctrl.reg_we = 1'b1;
      end
      OPC_JALR: begin
        ctrl.jump   = 1'b1;
        ctrl.wd_sel = WD_PC4;
        ctrl.reg_we = 1'b1;
      end
      OPC_BRANCH: begin
        ctrl.imm    = imm_b;
        ctrl.a_sel  = 1'b0;                  // alu forms the target
        ctrl.branch = 1'b1;
      end
      OPC_LOAD: begin
        ctrl.mem_en  = 1'b1;
        ctrl.is_load = 1'b1;
        ctrl.wd_sel  = WD_MEM;
        ctrl.reg_we  = 1'b1;
      end
      OPC_STORE: begin
        ctrl.imm        = imm_s;
        ctrl.mem_en     = 1'b1;
        ctrl.store_size = instr[13:12];      // 00 byte, 01 half, 10 word
      end
      OPC_OP_IMM: begin
        ctrl.alu_op = arith_op;
        ctrl.reg_we = 1'b1;
      end
      OPC_OP: begin
        ctrl.alu_op = arith_op;
        ctrl.b_sel  = 1'b1;
        ctrl.reg_we = 1'b1;
      end
      default: ;                             // anything else retires as a no-op
    endcase
  end

endmodule

`default_nettype wire

//--- ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

// decoded control of the instruction held in the instruction register
interface ctrl_if;
  import rv_pkg::*;

  alu_op_e     alu_op;
  logic        a_sel;      // 1 = rs1, 0 = pc
  logic        b_sel;      // 1 = rs2, 0 = immediate
  wd_sel_e     wd_sel;
  logic        reg_we;
  logic        mem_en;
  logic [1:0]  store_size;
  logic        jump;
  logic        branch;
  logic        is_load;
  logic [31:0] imm;
  logic [4:0]  rd, rs1, rs2;
  logic [2:0]  funct3;

  modport dec (output alu_op, a_sel, b_sel, wd_sel, reg_we, mem_en, store_size,
               jump, branch, is_load, imm, rd, rs1, rs2, funct3);
  modport usr (input alu_op, a_sel, b_sel, wd_sel, reg_we, mem_en, store_size,
               jump, branch, is_load, imm, rd, rs1, rs2, funct3);
endinterface

`default_nettype wire

//--- rv_pkg.sv
`default_nettype none

package rv_pkg;

  // rv32i major opcodes kept by the core
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  // register writeback source
  typedef enum logic [1:0] {
    WD_ALU = 2'b00,
    WD_MEM = 2'b01,
    WD_PC4 = 2'b10,
    WD_IMM = 2'b11
  } wd_sel_e;

  typedef enum logic [1:0] {
    ST_FETCH = 2'b00,
    ST_EXEC  = 2'b01,
    ST_MEM   = 2'b10
  } state_e;

  localparam logic [1:0] STORE_READ = 2'b11; // store_size code for a memory read

endpackage

`default_nettype wire
